//--- Makefile
TOP = tb_icache

.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Finished with no errors"

clean:
	rm -rf obj_dir

//--- sim/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int TIMEOUT   = 200;   // cycles allowed for any single wait
    localparam int NUM_STEPS = 21;

    typedef struct packed {
        logic [15:0] addr;
        logic        flush;   // entry is a flush, addr unused
        logic        miss;    // refill from memory expected
    } step_t;

    // set 1 holds tags 0/1/2 at 0x0010/0x0410/0x0810, set 5 at 0x1050
    localparam step_t STEPS [NUM_STEPS] = '{
        {16'h0010, 1'b0, 1'b1},   // A cold miss, fills way 0
        {16'h0010, 1'b0, 1'b0},   // A again
        {16'h0014, 1'b0, 1'b0},   // other offsets, same line
        {16'h001C, 1'b0, 1'b0},
        {16'h1050, 1'b0, 1'b1},   // D in set 5
        {16'h0410, 1'b0, 1'b1},   // B fills invalid way 1
        {16'h0010, 1'b0, 1'b0},
        {16'h0418, 1'b0, 1'b0},
        {16'h0810, 1'b0, 1'b1},   // C evicts way 0 (A)
        {16'h0018, 1'b0, 1'b1},   // A evicts way 1 (B)
        {16'h041C, 1'b0, 1'b1},   // B evicts way 0 (C)
        {16'h001C, 1'b0, 1'b0},   // A still in way 1
        {16'h1054, 1'b0, 1'b0},   // set 5 untouched by set 1 traffic
        {16'h0410, 1'b0, 1'b0},
        {16'h0000, 1'b1, 1'b0},   // flush
        {16'h0010, 1'b0, 1'b1},
        {16'h0410, 1'b0, 1'b1},
        {16'h1050, 1'b0, 1'b1},
        {16'h0810, 1'b0, 1'b1},   // both valid again, victim bit picks way 0
        {16'h0414, 1'b0, 1'b0},   // B survives in way 1
        {16'h0010, 1'b0, 1'b1}
    };

    logic              clk_i;
    logic              arst_n_i;
    logic              req_i;
    logic [15:0]       addr_i;
    logic              flush_i;
    logic              mem_valid_i;
    line_t             mem_line_i;
    logic              ready_o;
    logic              valid_o;
    line_t             line_o;
    logic              mem_req_o;
    logic [15:0]       mem_addr_o;

    int                seed = 23;
    int                delay;       // responder latency in cycles
    logic              req_seen;    // mem_req_o showed up for this request
    logic [15:0]       req_addr;    // mem_addr_o captured with it

    icache_top icache_top_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .addr_i      (addr_i),
        .flush_i     (flush_i),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .line_o      (line_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;   // 8 ns period
    end

    // memory content: word k of a line is its line address plus k
    function automatic line_t expected_line(logic [15:0] addr);
        line_t       line;
        logic [31:0] base;
        base = {16'h0000, addr[15:4], 4'h0};
        for (int k = 0; k < 4; k++) begin
            line[k*32 +: 32] = base + 32'(k);
        end
        return line;
    endfunction

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // ready_o only moves on rising edges, read it on the falling one
    task automatic wait_ready();
        int count;
        count = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
            count++;
            if (count > TIMEOUT) fail_timeout("ready_o");
        end
    endtask

    task automatic wait_valid();
        int count;
        count = 0;
        @(posedge clk_i);   // values seen here are the ones before the edge
        while (!valid_o) begin
            @(posedge clk_i);
            count++;
            if (count > TIMEOUT) fail_timeout("valid_o");
        end
    endtask

    task automatic run_request(logic [15:0] addr, logic miss);
        req_seen = 1'b0;
        req_i    = 1'b1;
        addr_i   = addr;
        @(posedge clk_i);   // accepting edge
        @(negedge clk_i);
        req_i    = 1'b0;
        wait_valid();
        check_value("line_o", line_o, expected_line(addr));
        check_value("mem_req_o", 128'(req_seen), 128'(miss));
        if (miss) begin
            check_value("mem_addr_o", 128'(req_addr), 128'({addr[15:4], 4'h0}));
        end
    endtask

    task automatic run_flush();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        check_value("ready_o", 128'(ready_o), 128'(1'b1));   // flush never blocks
    endtask

    // memory side, one line per mem_req_o after 1 to 6 cycles
    initial begin
        mem_valid_i = 1'b0;
        mem_line_i  = '0;
        forever begin
            @(posedge clk_i);
            if (mem_req_o) begin
                req_seen = 1'b1;
                req_addr = mem_addr_o;
                delay    = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay) @(negedge clk_i);
                mem_valid_i = 1'b1;
                mem_line_i  = expected_line(req_addr);
                @(negedge clk_i);
                mem_valid_i = 1'b0;
                mem_line_i  = '0;
            end
        end
    end

    initial begin
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        addr_i   = '0;
        flush_i  = 1'b0;
        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            wait_ready();
            if (STEPS[i].flush) begin
                run_flush();
            end else begin
                run_request(STEPS[i].addr, STEPS[i].miss);
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sources.f
verilog/icache_pkg.sv
verilog/set_ram.sv
verilog/icache_way.sv
verilog/icache_tag_array.sv
verilog/icache_replace.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
sim/tb_icache.sv

//--- verilog/icache_ctrl.sv
`timescale 1ns/1ns

// lookup and refill sequencing
// one request in flight, ready_o low while busy
module icache_ctrl (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                req_i,
    input  logic [icache_pkg::ADDR_WIDTH-1:0]   addr_i,
    input  logic                                flush_i,
    input  logic                                mem_valid_i,
    input  icache_pkg::line_t                   mem_line_i,
    input  icache_pkg::way_vec_t                hit_way_i,
    input  icache_pkg::way_vec_t                victim_i,
    input  icache_pkg::line_t                   way_line_i [icache_pkg::ICACHE_N_WAY],
    output logic                                ready_o,
    output logic                                valid_o,
    output icache_pkg::line_t                   line_o,
    output logic                                mem_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0]   mem_addr_o,
    output logic                                rd_o,
    output icache_pkg::index_t                  index_o,
    output icache_pkg::tag_t                    tag_o,
    output icache_pkg::way_vec_t                way_we_o,
    output logic                                flush_clear_o,
    output logic                                update_o,
    output icache_pkg::line_t                   fill_line_o
);
    import icache_pkg::*;

    typedef enum logic [1:0] {IDLE, LOOKUP, MISS_REQ, REFILL} state_t;

    state_t                state_q, state_d;
    logic [ADDR_WIDTH-1:0] addr_q;   // address of the request in flight
    logic                  accept;   // request taken this edge
    logic                  hit;      // lookup cycle found the line
    logic                  fill;     // refill line arriving

    assign ready_o       = (state_q == IDLE);
    assign flush_clear_o = ready_o & flush_i;             // flush wins over req
    assign accept        = ready_o & req_i & ~flush_i;
    assign hit           = (state_q == LOOKUP) & (|hit_way_i);
    assign fill          = (state_q == REFILL) & mem_valid_i;

    // rams read with the incoming index, later cycles use the latched one
    assign rd_o    = accept;
    assign index_o = ready_o ? addr_i[OFFSET_WIDTH +: INDEX_WIDTH]
                             : addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag_o   = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];

    // memory side
    assign mem_req_o  = (state_q == MISS_REQ);   // single cycle pulse
    assign mem_addr_o = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    // refill path
    assign way_we_o    = fill ? victim_i : '0;
    assign update_o    = fill;
    assign fill_line_o = mem_line_i;

    assign valid_o = hit | fill;

    // hit way select, memory line otherwise
    always_comb begin
        line_o = mem_line_i;
        if (state_q == LOOKUP) begin
            line_o = '0;
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                if (hit_way_i[w]) begin
                    line_o = way_line_i[w];
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (accept) state_d = LOOKUP;
            LOOKUP:   state_d = hit ? IDLE : MISS_REQ;
            MISS_REQ: state_d = REFILL;                    // request already out
            REFILL:   if (mem_valid_i) state_d = IDLE;     // variable latency
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= addr_i;   // held until the request completes
        end
    end

endmodule

//--- verilog/icache_pkg.sv
package icache_pkg;

    // address split is tag | index | offset
    localparam int ADDR_WIDTH   = 16;   // byte address from fetch
    localparam int OFFSET_WIDTH = 4;    // 16 bytes per line
    localparam int INDEX_WIDTH  = 6;    // selects one of the sets
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // geometry
    localparam int ICACHE_N_SET = 1 << INDEX_WIDTH;   // 64 sets
    localparam int ICACHE_N_WAY = 2;                   // two ways, one victim bit per set
    localparam int LINE_WIDTH   = 8 << OFFSET_WIDTH;   // 128 bit line

    // one full cache line, also the memory refill unit
    typedef logic [LINE_WIDTH-1:0]   line_t;

    // stored tag per way entry
    typedef logic [TAG_WIDTH-1:0]    tag_t;

    // set index into every ram of the cache
    typedef logic [INDEX_WIDTH-1:0]  index_t;

    // one bit per way, used for hit, valid, victim and write enables
    typedef logic [ICACHE_N_WAY-1:0] way_vec_t;

endpackage

//--- verilog/icache_replace.sv
`timescale 1ns/1ns

// victim choice per set
// invalid ways go first, else the set's victim bit decides
module icache_replace (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  icache_pkg::index_t   index_i,
    input  icache_pkg::way_vec_t valid_way_i,   // valid bits of the set
    input  logic                 update_i,      // refill done on this set
    output icache_pkg::way_vec_t victim_o       // one hot
);
    import icache_pkg::*;

    logic [ICACHE_N_SET-1:0] victim_q;   // one bit per set, names the next way

    always_comb begin
        victim_o = '0;
        victim_o[victim_q[index_i]] = 1'b1;   // default from victim bit
        // walk down so the lowest invalid way wins
        for (int w = ICACHE_N_WAY - 1; w >= 0; w--) begin
            if (!valid_way_i[w]) begin
                victim_o    = '0;
                victim_o[w] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            victim_q <= '0;
        end else if (update_i) begin
            victim_q[index_i] <= ~victim_o[1];   // point at the way after the filled one
        end
    end

endmodule

//--- verilog/icache_tag_array.sv
`timescale 1ns/1ns

// tags in rams, valid bits in flops
// hit is evaluated the cycle after the read
module icache_tag_array (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 rd_i,           // lookup read
    input  icache_pkg::index_t   index_i,
    input  icache_pkg::tag_t     tag_i,          // held from the latched address
    input  icache_pkg::way_vec_t way_we_i,       // refill write per way
    input  logic                 flush_clear_i,  // drop every valid bit
    output icache_pkg::way_vec_t hit_way_o,
    output icache_pkg::way_vec_t valid_way_o
);
    import icache_pkg::*;

    logic [ICACHE_N_SET-1:0] valid_q [ICACHE_N_WAY];   // valid bit per set, per way
    index_t                  idx_q;                    // index of the last lookup
    tag_t                    tag_rd [ICACHE_N_WAY];    // stored tags of that set

    // keep the looked up set so valid and tag line up
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idx_q <= '0;
        end else if (rd_i) begin
            idx_q <= index_i;
        end
    end

    // valid flops, flush clears all sets in one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '{default: '0};
        end else if (flush_clear_i) begin
            valid_q <= '{default: '0};
        end else begin
            for (int w = 0; w < ICACHE_N_WAY; w++) begin
                if (way_we_i[w]) begin
                    valid_q[w][index_i] <= 1'b1;   // refilled entry becomes valid
                end
            end
        end
    end

    genvar w;
    generate
        for (w = 0; w < ICACHE_N_WAY; w++) begin : gen_tag_way
            logic chip_en;   // read on lookup, write on refill

            assign chip_en = rd_i | way_we_i[w];

            set_ram #(
                .word_t (tag_t)
            ) tag_ram_inst (
                .clk_i  (clk_i),
                .req_i  (chip_en),
                .we_i   (way_we_i[w]),
                .addr_i (index_i),
                .data_i (tag_i),
                .data_o (tag_rd[w])
            );

            assign valid_way_o[w] = valid_q[w][idx_q];
            // match only counts on a valid entry
            assign hit_way_o[w]   = valid_way_o[w] & (tag_rd[w] == tag_i);
        end
    endgenerate

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ns

// two way instruction cache
// fetch side in front, line refill from memory behind
module icache_top (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              req_i,        // fetch strobe
    input  logic [icache_pkg::ADDR_WIDTH-1:0] addr_i,       // byte address
    input  logic                              flush_i,      // invalidate all
    input  logic                              mem_valid_i,  // refill line present
    input  icache_pkg::line_t                 mem_line_i,
    output logic                              ready_o,
    output logic                              valid_o,
    output icache_pkg::line_t                 line_o,
    output logic                              mem_req_o,
    output logic [icache_pkg::ADDR_WIDTH-1:0] mem_addr_o    // line aligned
);
    import icache_pkg::*;

    logic     rd;
    index_t   index;
    tag_t     tag;
    way_vec_t way_we;
    logic     flush_clear;
    logic     update;
    line_t    fill_line;
    way_vec_t hit_way;
    way_vec_t valid_way;
    way_vec_t victim;
    line_t    way_line [ICACHE_N_WAY];   // read data per way

    icache_ctrl ctrl_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .flush_i       (flush_i),
        .mem_valid_i   (mem_valid_i),
        .mem_line_i    (mem_line_i),
        .hit_way_i     (hit_way),
        .victim_i      (victim),
        .way_line_i    (way_line),
        .ready_o       (ready_o),
        .valid_o       (valid_o),
        .line_o        (line_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .rd_o          (rd),
        .index_o       (index),
        .tag_o         (tag),
        .way_we_o      (way_we),
        .flush_clear_o (flush_clear),
        .update_o      (update),
        .fill_line_o   (fill_line)
    );

    icache_tag_array tag_array_inst (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .rd_i          (rd),
        .index_i       (index),
        .tag_i         (tag),
        .way_we_i      (way_we),
        .flush_clear_i (flush_clear),
        .hit_way_o     (hit_way),
        .valid_way_o   (valid_way)
    );

    icache_replace replace_inst (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .index_i     (index),
        .valid_way_i (valid_way),
        .update_i    (update),
        .victim_o    (victim)
    );

    genvar w;
    generate
        for (w = 0; w < ICACHE_N_WAY; w++) begin : gen_way
            icache_way way_inst (
                .clk_i  (clk_i),
                .req_i  (rd),
                .we_i   (way_we[w]),   // only the victim way is written
                .addr_i (index),
                .data_i (fill_line),
                .data_o (way_line[w])
            );
        end
    endgenerate

endmodule

//--- verilog/icache_way.sv
`timescale 1ns/1ns

// line storage of a single way
// the controller raises either a lookup read or a refill write
module icache_way (
    input  logic               clk_i,
    input  logic               req_i,    // lookup read strobe
    input  logic               we_i,     // refill write strobe
    input  icache_pkg::index_t addr_i,
    input  icache_pkg::line_t  data_i,   // refill line
    output icache_pkg::line_t  data_o    // line read at previous lookup
);
    import icache_pkg::*;

    logic chip_en;   // ram active on read or write

    // a refill write also needs the ram enabled
    assign chip_en = req_i | we_i;

    set_ram #(
        .word_t (line_t)
    ) line_ram_inst (
        .clk_i  (clk_i),
        .req_i  (chip_en),
        .we_i   (we_i),
        .addr_i (addr_i),
        .data_i (data_i),
        .data_o (data_o)
    );

endmodule

//--- verilog/set_ram.sv
`timescale 1ns/1ns

// generic single port ram, one word per set
// used for line storage and for tag storage
module set_ram #(
    parameter type word_t = logic
) (
    input  logic               clk_i,
    input  logic               req_i,   // chip enable
    input  logic               we_i,    // write when enabled, else read
    input  icache_pkg::index_t addr_i,
    input  word_t              data_i,
    output word_t              data_o
);
    import icache_pkg::*;

    word_t mem_q [ICACHE_N_SET];   // storage array
    word_t rd_q;                   // registered read word

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= data_i;   // write, read port holds old value
            end else begin
                rd_q <= mem_q[addr_i];     // read shows up next cycle
            end
        end
    end

    // no write-through, data_o only changes on a read
    assign data_o = rd_q;

endmodule
